//--- hdl/ifc_pkg.sv
// Shared sizes and types of the fetch controller, imported by every fetch block
`default_nettype none

package ifc_pkg;

   // ******************************************************************
   // Sizes
   // ******************************************************************
   localparam int PC_W              = 31;             // Halfword address, bits 31:1
   localparam int LINE_BIT          = 6;              // 64-byte icache lines
   localparam int FB_SLOTS          = 5;
   localparam int FB_CREDITS        = FB_SLOTS - 1;
   localparam logic [31:0] ICCM_SADR = 32'hEE00_0000;
   localparam int ICCM_SIZE_KB      = 64;
   localparam int REGION_W          = 4;              // Top address bits select the region

   // ******************************************************************
   // Fetch address, decoded two ways
   // ******************************************************************
   typedef struct packed {
      logic [REGION_W-1:0]      region;
      logic [PC_W-REGION_W-1:0] offset;
   } region_view_t;

   typedef struct packed {
      logic [PC_W-3:0] line;    // Bits 31:3
      logic [1:0]      word;    // Bits 2:1
   } line_view_t;

   typedef union packed {
      logic [PC_W-1:0] raw;
      region_view_t    region_view;
      line_view_t      line_view;
   } fetch_addr_u;

   // ******************************************************************
   // Grouped control signals
   // ******************************************************************
   typedef struct packed {
      logic        flush;
      logic        noredir;   // Halt, no refetch after the flush
      fetch_addr_u path;
   } flush_t;

   typedef struct packed {
      logic ic_dma_active;
      logic ic_write_stall;
      logic dma_iccm_stall;
   } stall_t;

   typedef struct packed {
      logic consume1;
      logic consume2;
   } fb_credit_t;

   typedef struct packed {
      logic iccm_access;
      logic region_fault;
      logic uncacheable;
   } f1_attr_t;

   typedef enum logic [1:0] {
      idle  = 2'b00,
      fetch = 2'b01,
      stall = 2'b10,
      wfm   = 2'b11
   } fetch_state_e;

endpackage

`default_nettype wire

//--- hdl/ifc_fetch_fsm.sv
// Fetch state machine, tracks idle, fetch, stall and wait-for-miss for the address path
`timescale 1ns/1ps
`default_nettype none

module ifc_fetch_fsm
   import ifc_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  flush_t flush_in,
   input  logic   miss_f2,
   input  logic   miss_a,
   input  logic   dma_stall,
   input  logic   ic_mb_empty,
   output logic   fetch_ns,
   output logic   is_wfm,
   output logic   is_idle
);

   fetch_state_e state, next_state;
   logic         goto_idle, leave_idle, mb_empty_mod;

   assign goto_idle  = flush_in.flush & flush_in.noredir;    // Halt
   assign leave_idle = flush_in.flush & ~flush_in.noredir;

   // Miss buffer drained and nothing left in flight
   assign mb_empty_mod = (ic_mb_empty | flush_in.flush) & ~dma_stall & ~miss_f2 & ~miss_a;

   always_comb begin
      next_state = state;
      if (goto_idle) begin
         next_state = idle;
      end else begin
         unique case (state)
            idle:  next_state = leave_idle ? fetch : idle;
            fetch: next_state = miss_f2 ? wfm : fetch;
            stall: next_state = mb_empty_mod ? idle : stall;
            wfm:   next_state = mb_empty_mod ? fetch : wfm;
            default: next_state = idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   assign fetch_ns = (next_state == fetch);
   assign is_wfm   = (state == wfm);
   assign is_idle  = (state == idle);

   // Only execute can wake the fetch unit up
   a_idle_needs_flush: assert property (@(posedge clk) disable iff (rst)
      (state == idle && !flush_in.flush) |=> (state == idle));

endmodule

`default_nettype wire

//--- hdl/ifc_addr_sel.sv
// Next fetch address mux with the miss replay register and the F1/F2 address registers
`timescale 1ns/1ps
`default_nettype none

module ifc_addr_sel
   import ifc_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  flush_t      flush_in,
   input  logic        bp_kill_next_f2,
   input  fetch_addr_u bp_target_f2,
   input  logic        ic_hit_f2,
   input  logic        fetch_req_f1,     // F1 accepted
   input  logic        fetch_req_f2,
   input  logic        fetch_ns,
   input  logic        is_wfm,
   input  logic        is_idle,
   input  logic        dma_stall,
   input  logic        ic_write_stall,
   output fetch_addr_u fetch_addr_bf,
   output fetch_addr_u fetch_addr_f1,
   output fetch_addr_u fetch_addr_f2,
   output logic        fetch_req_bf
);

   fetch_addr_u     f1_q, miss_addr, miss_addr_ns, next_addr;
   logic [PC_W-3:0] next_line;
   logic            line_wrap, kill_f2, flush;
   logic            sel_flush, sel_miss, sel_btb, sel_last, sel_next;
   logic            miss_sel_f2, miss_sel_f1, miss_en;

   assign flush   = flush_in.flush;
   assign kill_f2 = bp_kill_next_f2 & fetch_req_f2;   // Taken branch in F2

   // ******************************************************************
   // Sequential address, next line with wrap at the cache line
   // ******************************************************************
   assign next_line = fetch_addr_f1.line_view.line + 1'b1;
   assign line_wrap = next_line[LINE_BIT-3] ^ fetch_addr_f1.line_view.line[LINE_BIT-3];
   assign next_addr = {next_line, line_wrap ? 2'b00 : fetch_addr_f1.line_view.word};

   // ******************************************************************
   // Address select
   // ******************************************************************
   // Flush path goes straight to BF only when it cannot be fetched now
   assign sel_flush = flush & (is_wfm | is_idle | dma_stall | ic_write_stall);
   assign sel_btb   = ~sel_flush & kill_f2;
   assign sel_next  = ~sel_flush & fetch_req_f1;
   assign sel_last  = ~sel_flush & ~kill_f2 & ~fetch_req_f1 & fetch_req_f2;
   assign sel_miss  = ~sel_flush & ~kill_f2 & ~fetch_req_f1 & ~fetch_req_f2;

   always_comb begin
      fetch_addr_bf = miss_addr;
      if (sel_flush) begin
         fetch_addr_bf = flush_in.path;
      end else if (sel_btb) begin
         fetch_addr_bf = bp_target_f2;
      end else if (sel_last) begin
         fetch_addr_bf = fetch_addr_f1;
      end else if (sel_next) begin
         fetch_addr_bf = next_addr;
      end
   end

   assign fetch_req_bf = fetch_ns;

   // Miss register, holds whatever has to be refetched later
   assign miss_sel_f2 = ~ic_hit_f2 & fetch_req_f2;
   assign miss_sel_f1 = fetch_req_f2 & ~fetch_req_f1 & ~kill_f2;
   assign miss_en     = flush | miss_sel_f2 | kill_f2 | (fetch_req_f2 & ~fetch_req_f1);

   always_comb begin
      miss_addr_ns = fetch_addr_bf;
      if (sel_flush) begin
         miss_addr_ns = flush_in.path;
      end else if (miss_sel_f2) begin
         miss_addr_ns = fetch_addr_f2;   // Icache miss, replay F2
      end else if (miss_sel_f1) begin
         miss_addr_ns = fetch_addr_f1;   // F1 not accepted
      end
   end

   // ******************************************************************
   // Registers
   // ******************************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         miss_addr <= '0;
         f1_q      <= '0;
      end else begin
         if (miss_en) begin
            miss_addr <= miss_addr_ns;
         end
         if (fetch_ns) begin
            f1_q <= fetch_addr_bf;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_req_f1) begin
         fetch_addr_f2 <= fetch_addr_f1;
      end
   end

   // A flush redirects F1 in the same cycle
   assign fetch_addr_f1 = flush ? flush_in.path : f1_q;

   a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot({sel_flush, sel_miss, sel_btb, sel_last, sel_next}));

endmodule

`default_nettype wire

//--- hdl/ifc_req_pipe.sv
// F1 and F2 fetch request pipeline, qualifies F1 and detects the F2 icache miss
`timescale 1ns/1ps
`default_nettype none

module ifc_req_pipe
   import ifc_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  logic   fetch_req_bf,
   input  logic   ic_hit_f2,
   input  flush_t flush_in,
   input  logic   bp_kill_next_f2,
   input  logic   fb_full,
   input  logic   credit_return,
   input  stall_t stall_in,
   output logic   fetch_req_f1,
   output logic   fetch_req_f2,
   output logic   miss_f2,
   output logic   miss_a,
   output logic   dma_stall,
   output logic   dma_iccm_stall_q
);

   logic fetch_req_f1_raw, f1_unqual, f2_raw, f2_ns;
   logic halt, kill_f1, fb_block;

   assign dma_stall = stall_in.ic_dma_active | dma_iccm_stall_q;
   assign halt      = flush_in.flush & flush_in.noredir;
   assign kill_f1   = bp_kill_next_f2 & f2_raw;                      // BTB redirect
   assign fb_block  = fb_full & ~(credit_return | flush_in.flush);   // No credit left

   assign fetch_req_f1_raw = f1_unqual & ~miss_a;

   // ******************************************************************
   // F1 qualification
   // ******************************************************************
   assign fetch_req_f1 = fetch_req_f1_raw &
                         ~kill_f1 &
                         ~fb_block &
                         ~dma_stall &
                         ~stall_in.ic_write_stall &
                         ~halt;

   // Missed fetch kills whatever is behind it
   assign f2_ns        = fetch_req_f1 & ~miss_f2 & ~miss_a;
   assign fetch_req_f2 = f2_raw & ~flush_in.flush;
   assign miss_f2      = fetch_req_f2 & ~ic_hit_f2;

   always_ff @(posedge clk) begin
      if (rst) begin
         f1_unqual        <= 1'b0;
         f2_raw           <= 1'b0;
         miss_a           <= 1'b0;
         dma_iccm_stall_q <= 1'b0;
      end else begin
         f1_unqual        <= fetch_req_bf;
         f2_raw           <= f2_ns;
         miss_a           <= miss_f2;
         dma_iccm_stall_q <= stall_in.dma_iccm_stall;
      end
   end

   a_f2_after_f1: assert property (@(posedge clk) disable iff (rst)
      fetch_req_f2 |-> $past(fetch_req_f1));

endmodule

`default_nettype wire

//--- hdl/ifc_fb_credit.sv
// Fetch-buffer occupancy as a one-hot write pointer, gives the buffer-full back-pressure
`timescale 1ns/1ps
`default_nettype none

module ifc_fb_credit
   import ifc_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  fb_credit_t credit_in,
   input  flush_t     flush_in,
   input  logic       fetch_req_f1,
   input  logic       miss_f2,
   output logic       fb_full,
   output logic       credit_return
);

   logic [FB_SLOTS-1:0] fb_write, fb_write_ns;
   logic                c1, c2;
   logic                fb_right, fb_right2, fb_right3, fb_left;

   assign c1 = credit_in.consume1 & ~credit_in.consume2;
   assign c2 = credit_in.consume2;

   assign credit_return = credit_in.consume1 | credit_in.consume2;

   // ******************************************************************
   // Pointer moves, a missed F2 gives its slot back
   // ******************************************************************
   assign fb_right  = (~c1 & ~c2 & miss_f2) |
                      (c1 & ~fetch_req_f1 & ~miss_f2) |
                      (c2 & fetch_req_f1 & ~miss_f2);
   assign fb_right2 = (c1 & miss_f2) |
                      (c2 & ~fetch_req_f1 & ~miss_f2);
   assign fb_right3 = c2 & miss_f2;
   assign fb_left   = fetch_req_f1 & ~c1 & ~c2 & ~miss_f2;   // New fetch, no return

   always_comb begin
      fb_write_ns = fb_write;
      if (flush_in.flush) begin
         fb_write_ns = fetch_req_f1 ? FB_SLOTS'(2) : FB_SLOTS'(1);
      end else if (fb_right3) begin
         fb_write_ns = fb_write >> 3;
      end else if (fb_right2) begin
         fb_write_ns = fb_write >> 2;
      end else if (fb_right) begin
         fb_write_ns = fb_write >> 1;
      end else if (fb_left) begin
         fb_write_ns = fb_write << 1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         fb_write <= FB_SLOTS'(1);
         fb_full  <= 1'b0;
      end else begin
         fb_write <= fb_write_ns;
         fb_full  <= fb_write_ns[FB_SLOTS-1];   // Top slot reached
      end
   end

   a_ptr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(fb_write));

endmodule

`default_nettype wire

//--- hdl/ifc_mem_attr.sv
// F1 memory attributes from the ICCM range and MRAC, plus the DMA grant to the ICCM
`timescale 1ns/1ps
`default_nettype none

module ifc_mem_attr
   import ifc_pkg::*;
(
   input  fetch_addr_u fetch_addr_f1,
   input  logic [31:0] mrac,
   input  logic        fb_full,
   input  logic        credit_return,
   input  logic        is_wfm,
   input  logic        is_idle,
   input  flush_t      flush_in,
   input  logic        dma_iccm_stall_q,
   output f1_attr_t    attr_f1,
   output logic        dma_access_ok
);

   logic [31:0]         byte_addr, iccm_offset;
   logic [REGION_W-1:0] region;
   logic                in_region, in_range;

   assign region    = fetch_addr_f1.region_view.region;
   assign byte_addr = {fetch_addr_f1.raw, 1'b0};

   // Offset wraps for addresses below the base
   assign iccm_offset = byte_addr - ICCM_SADR;
   assign in_range    = iccm_offset < 32'(ICCM_SIZE_KB * 1024);
   assign in_region   = (region == ICCM_SADR[31 -: REGION_W]);

   assign attr_f1.iccm_access  = in_range;
   assign attr_f1.region_fault = in_region & ~in_range;   // ICCM region, past the end
   assign attr_f1.uncacheable  = ~mrac[{region, 1'b0}];   // Cacheable bit per region

   // DMA may use the ICCM when fetch is not about to
   assign dma_access_ok = ((~attr_f1.iccm_access |
                            (fb_full & ~credit_return) |
                            is_wfm |
                            is_idle) & ~flush_in.flush) |
                          dma_iccm_stall_q;

endmodule

`default_nettype wire

//--- hdl/ifc_fetch_top.sv
// Fetch controller top, connects the FSM, address, request, credit and attribute blocks
`timescale 1ns/1ps
`default_nettype none

module ifc_fetch_top
   import ifc_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  flush_t      flush_in,          // From execute
   input  stall_t      stall_in,          // From icache and DMA
   input  fb_credit_t  credit_in,         // From the aligner
   input  logic        ic_hit_f2,
   input  logic        ic_mb_empty,
   input  logic        bp_kill_next_f2,
   input  fetch_addr_u bp_target_f2,
   input  logic [31:0] mrac,
   output logic        fetch_req_bf,
   output logic        fetch_req_f1,
   output logic        fetch_req_f2,
   output fetch_addr_u fetch_addr_bf,
   output fetch_addr_u fetch_addr_f1,
   output fetch_addr_u fetch_addr_f2,
   output f1_attr_t    attr_f1,
   output logic        dma_access_ok
);

   logic fetch_ns, is_wfm, is_idle;
   logic miss_f2, miss_a, dma_stall, dma_iccm_stall_q;
   logic fb_full, credit_return;

   ifc_fetch_fsm fsm_i (
      .clk         (clk),
      .rst         (rst),
      .flush_in    (flush_in),
      .miss_f2     (miss_f2),
      .miss_a      (miss_a),
      .dma_stall   (dma_stall),
      .ic_mb_empty (ic_mb_empty),
      .fetch_ns    (fetch_ns),
      .is_wfm      (is_wfm),
      .is_idle     (is_idle)
   );

   ifc_addr_sel addr_sel_i (
      .clk             (clk),
      .rst             (rst),
      .flush_in        (flush_in),
      .bp_kill_next_f2 (bp_kill_next_f2),
      .bp_target_f2    (bp_target_f2),
      .ic_hit_f2       (ic_hit_f2),
      .fetch_req_f1    (fetch_req_f1),
      .fetch_req_f2    (fetch_req_f2),
      .fetch_ns        (fetch_ns),
      .is_wfm          (is_wfm),
      .is_idle         (is_idle),
      .dma_stall       (dma_stall),
      .ic_write_stall  (stall_in.ic_write_stall),
      .fetch_addr_bf   (fetch_addr_bf),
      .fetch_addr_f1   (fetch_addr_f1),
      .fetch_addr_f2   (fetch_addr_f2),
      .fetch_req_bf    (fetch_req_bf)
   );

   ifc_req_pipe req_pipe_i (
      .clk              (clk),
      .rst              (rst),
      .fetch_req_bf     (fetch_req_bf),
      .ic_hit_f2        (ic_hit_f2),
      .flush_in         (flush_in),
      .bp_kill_next_f2  (bp_kill_next_f2),
      .fb_full          (fb_full),
      .credit_return    (credit_return),
      .stall_in         (stall_in),
      .fetch_req_f1     (fetch_req_f1),
      .fetch_req_f2     (fetch_req_f2),
      .miss_f2          (miss_f2),
      .miss_a           (miss_a),
      .dma_stall        (dma_stall),
      .dma_iccm_stall_q (dma_iccm_stall_q)
   );

   ifc_fb_credit fb_credit_i (
      .clk           (clk),
      .rst           (rst),
      .credit_in     (credit_in),
      .flush_in      (flush_in),
      .fetch_req_f1  (fetch_req_f1),
      .miss_f2       (miss_f2),
      .fb_full       (fb_full),
      .credit_return (credit_return)
   );

   ifc_mem_attr mem_attr_i (
      .fetch_addr_f1    (fetch_addr_f1),
      .mrac             (mrac),
      .fb_full          (fb_full),
      .credit_return    (credit_return),
      .is_wfm           (is_wfm),
      .is_idle          (is_idle),
      .flush_in         (flush_in),
      .dma_iccm_stall_q (dma_iccm_stall_q),
      .attr_f1          (attr_f1),
      .dma_access_ok    (dma_access_ok)
   );

endmodule

`default_nettype wire

//--- test/ifc_clk_gen.sv
// Free-running clock for the fetch controller testbench, 20 ns period
`timescale 1ns/1ps
`default_nettype none

module ifc_clk_gen (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // Half period
   end

endmodule

`default_nettype wire

//--- test/ifc_fetch_tb.sv
// Testbench for the fetch controller, runs the command lines of the test data file against the DUT
`timescale 1ns/1ps
`default_nettype none

module ifc_fetch_tb
   import ifc_pkg::*;
();

   logic        clk, rst;
   flush_t      flush_in;
   stall_t      stall_in;
   fb_credit_t  credit_in;
   logic        ic_hit_f2, ic_mb_empty, bp_kill_next_f2;
   fetch_addr_u bp_target_f2;
   logic [31:0] mrac;
   logic        fetch_req_bf, fetch_req_f1, fetch_req_f2;
   fetch_addr_u fetch_addr_bf, fetch_addr_f1, fetch_addr_f2;
   f1_attr_t    attr_f1;
   logic        dma_access_ok;

   int              errors, test_errors, tests_done, cur_test;
   int              cycles, cycle_limit;
   int              f1_count, busy_count;
   logic [PC_W-1:0] last_f1;            // Expected address of the last F1

   // Parsed test data
   int          tnum_q[$];
   logic [63:0] cmd_q[$];
   logic [31:0] arg_q[$];
   logic [31:0] exp_q[$];

   ifc_clk_gen clk_gen_i (.clk(clk));

   ifc_fetch_top dut_i (
      .clk             (clk),
      .rst             (rst),
      .flush_in        (flush_in),
      .stall_in        (stall_in),
      .credit_in       (credit_in),
      .ic_hit_f2       (ic_hit_f2),
      .ic_mb_empty     (ic_mb_empty),
      .bp_kill_next_f2 (bp_kill_next_f2),
      .bp_target_f2    (bp_target_f2),
      .mrac            (mrac),
      .fetch_req_bf    (fetch_req_bf),
      .fetch_req_f1    (fetch_req_f1),
      .fetch_req_f2    (fetch_req_f2),
      .fetch_addr_bf   (fetch_addr_bf),
      .fetch_addr_f1   (fetch_addr_f1),
      .fetch_addr_f2   (fetch_addr_f2),
      .attr_f1         (attr_f1),
      .dma_access_ok   (dma_access_ok)
   );

   // Run limit, 200 cycles per test
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Test %0d timed out after %0d cycles", cur_test, cycles);
         $display("Errors found");
         $finish;
      end
   end

   // ******************************************************************
   // Reference rules
   // ******************************************************************
   // Next line is 8 bytes on, halfword offset dropped when bit 6 flips
   function automatic logic [31:0] seq_byte_addr(input logic [31:0] b);
      logic [31:0] nb;
      nb = b + 32'd8;
      if (nb[LINE_BIT] != b[LINE_BIT]) begin
         nb[2:1] = 2'b00;
      end
      return nb;
   endfunction

   function automatic f1_attr_t expect_attr(input logic [31:0] b);
      f1_attr_t a;
      logic [REGION_W-1:0] reg_num;
      reg_num        = b[31 -: REGION_W];
      a.iccm_access  = (b >= ICCM_SADR) && (b < ICCM_SADR + 32'(ICCM_SIZE_KB * 1024));
      a.region_fault = (reg_num == ICCM_SADR[31 -: REGION_W]) && !a.iccm_access;
      a.uncacheable  = !mrac[2 * reg_num];
      return a;
   endfunction

   // ******************************************************************
   // Checking and sampling
   // ******************************************************************
   task automatic check_val(input logic [31:0] got, input logic [31:0] want,
                            input string msg);
      if (got !== want) begin
         $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, want);
         errors++;
         test_errors++;
      end
   endtask

   // Looks at one cycle on the falling edge
   task automatic sample_cycle();
      f1_attr_t want_attr;
      @(negedge clk);
      if (fetch_req_bf || fetch_req_f1 || fetch_req_f2) begin
         busy_count++;
      end
      if (fetch_req_f1) begin
         f1_count++;
         want_attr = expect_attr({fetch_addr_f1.raw, 1'b0});
         check_val(attr_f1, want_attr, "F1 attributes");
         // A requesting F1 owns the ICCM when its address lies there
         check_val(dma_access_ok, !flush_in.flush && !want_attr.iccm_access,
                   "DMA access grant");
      end
   endtask

   task automatic wait_f1();
      do begin
         sample_cycle();
      end while (!fetch_req_f1);
   endtask

   task automatic wait_f2();
      do begin
         sample_cycle();
      end while (!fetch_req_f2);
   endtask

   task automatic report_test();
      $display("Test %0d finished with %0d errors", cur_test, test_errors);
      tests_done++;
      test_errors = 0;
   endtask

   // ******************************************************************
   // Commands
   // ******************************************************************
   task automatic do_flush(input logic [31:0] addr, input logic halt, input logic hit);
      @(posedge clk);
      flush_in.flush   <= 1'b1;
      flush_in.noredir <= halt;
      flush_in.path    <= addr[31:1];
      ic_hit_f2        <= hit;
      @(negedge clk);
      if (!halt) begin   // Redirect from idle, path goes to BF at once
         check_val(fetch_req_bf, 1'b1, "BF request in the flush cycle");
         check_val({fetch_addr_bf.raw, 1'b0}, {addr[31:1], 1'b0},
                   "BF address in the flush cycle");
      end
      @(posedge clk);
      flush_in.flush   <= 1'b0;
      flush_in.noredir <= 1'b0;
   endtask

   task automatic run_seq(input int n);
      logic [31:0] want;
      @(posedge clk);
      credit_in.consume1 <= 1'b1;   // Aligner drains every cycle
      for (int i = 0; i < n; i++) begin
         wait_f1();
         want = seq_byte_addr({last_f1, 1'b0});
         check_val({fetch_addr_f1.raw, 1'b0}, want, "Sequential F1 address");
         last_f1 = want[31:1];
      end
      @(posedge clk);
      credit_in.consume1 <= 1'b0;
   endtask

   task automatic consume_count(input logic [31:0] pulses, input logic [31:0] exp);
      f1_count = 0;
      if (pulses != 0) begin
         @(posedge clk);
         credit_in.consume1 <= 1'b1;
         sample_cycle();
         @(posedge clk);
         credit_in.consume1 <= 1'b0;
      end
      repeat (30) sample_cycle();
      check_val(f1_count, exp, "F1 requests accepted");
   endtask

   task automatic miss_replay(input logic [31:0] addr, input logic [31:0] exp);
      int gap;
      do_flush(addr, 1'b0, 1'b0);
      wait_f2();
      check_val({fetch_addr_f2.raw, 1'b0}, addr, "Missed F2 address");
      @(posedge clk);
      ic_hit_f2 <= 1'b1;
      f1_count = 0;
      gap = $urandom_range(9, 2);
      repeat (gap) sample_cycle();
      check_val(f1_count, 0, "F1 requests during miss wait");
      @(posedge clk);
      ic_mb_empty <= 1'b1;
      wait_f1();
      check_val({fetch_addr_f1.raw, 1'b0}, exp, "Refetch address after miss");
      last_f1 = exp[31:1];
      @(posedge clk);
      ic_mb_empty <= 1'b0;
   endtask

   task automatic btb_kill(input logic [31:0] target, input logic [31:0] exp);
      wait_f2();
      @(posedge clk);
      bp_kill_next_f2 <= 1'b1;
      bp_target_f2    <= target[31:1];
      sample_cycle();
      check_val(fetch_req_f1, 0, "F1 request in the kill cycle");
      @(posedge clk);
      bp_kill_next_f2 <= 1'b0;
      wait_f1();
      check_val({fetch_addr_f1.raw, 1'b0}, exp, "F1 address after BTB kill");
      last_f1 = exp[31:1];
   endtask

   task automatic halt_check(input logic [31:0] exp);
      do_flush(32'h0, 1'b1, 1'b1);
      busy_count = 0;
      repeat (10) sample_cycle();
      check_val(busy_count, exp, "Cycles with a request after halt");
   endtask

   // ******************************************************************
   // Main sequence
   // ******************************************************************
   initial begin
      int          fd, code, tnum, n_tests, prev_tnum;
      logic [63:0]    cmd;
      logic [31:0]    arg, exp;
      logic [8*128-1:0] line;

      rst             = 1'b1;
      flush_in        = '0;
      stall_in        = '0;
      credit_in       = '0;
      ic_hit_f2       = 1'b1;
      ic_mb_empty     = 1'b0;
      bp_kill_next_f2 = 1'b0;
      bp_target_f2    = '0;
      mrac            = 32'h5A5A_A5A5;
      errors          = 0;
      test_errors     = 0;
      tests_done      = 0;
      cycles          = 0;
      cycle_limit     = 0;
      last_f1         = '0;
      cur_test        = 0;
      f1_count        = 0;
      busy_count      = 0;
      void'($urandom(59));

      fd = $fopen("test/ifc_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test data file");
         $display("Errors found");
         $finish;
      end else begin
         n_tests   = 0;
         prev_tnum = -1;
         while (!$feof(fd)) begin
            line = '0;
            code = $fgets(line, fd);
            code = $sscanf(line, "%d %s %h %h", tnum, cmd, arg, exp);
            if (code == 4) begin      // Comments and blank lines fail the scan
               tnum_q.push_back(tnum);
               cmd_q.push_back(cmd);
               arg_q.push_back(arg);
               exp_q.push_back(exp);
               if (tnum != prev_tnum) begin
                  n_tests++;
               end
               prev_tnum = tnum;
            end
         end
         $fclose(fd);

         cycle_limit = 200 * n_tests;
         repeat (16) @(posedge clk);
         rst <= 1'b0;

         if (tnum_q.size() > 0) begin
            cur_test = tnum_q[0];
         end

         // Nothing may be fetched before the first flush
         busy_count = 0;
         repeat (4) sample_cycle();
         check_val(busy_count, 0, "Cycles with a request before the first flush");

         foreach (cmd_q[i]) begin
            if (tnum_q[i] != cur_test) begin
               report_test();
               cur_test = tnum_q[i];
            end
            if (cmd_q[i] == "flush" || cmd_q[i] == "halt" || cmd_q[i] == "miss") begin
               repeat ($urandom_range(5, 0)) @(posedge clk);   // Idle gap
            end
            case (cmd_q[i])
               "flush": begin
                  do_flush(arg_q[i], 1'b0, 1'b1);
                  wait_f1();
                  check_val({fetch_addr_f1.raw, 1'b0}, exp_q[i], "First F1 after flush");
                  exp     = exp_q[i];
                  last_f1 = exp[31:1];
               end
               "run":     run_seq(exp_q[i]);
               "consume": consume_count(arg_q[i], exp_q[i]);
               "miss":    miss_replay(arg_q[i], exp_q[i]);
               "kill":    btb_kill(arg_q[i], exp_q[i]);
               "halt":    halt_check(exp_q[i]);
               default: begin
                  $display("Unknown command on test data line %0d", i);
                  errors++;
               end
            endcase
         end
         report_test();

         $display("Tests run: %0d, errors: %0d", tests_done, errors);
         if (errors == 0) begin
            $display("No errors");
         end else begin
            $display("Errors found");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- test/ifc_testdata.txt
# Columns: test number, command, byte address or pulse count (hex), expected value (hex)
# Commands: flush, halt, run, miss, kill, consume
1 halt 00000000 00000000
2 flush 80001234 80001234
2 run 00000000 0000000c
2 halt 00000000 00000000
3 flush 40000100 40000100
3 consume 00000000 00000003
3 consume 00000001 00000001
3 halt 00000000 00000000
4 miss 20000040 20000040
4 halt 00000000 00000000
5 flush 30000000 30000000
5 kill 30000a08 30000a08
5 halt 00000000 00000000
6 flush ee00ffe4 ee00ffe4
6 run 00000000 00000008
6 halt 00000000 00000000

//--- ifc_fetch_top.f
hdl/ifc_pkg.sv
hdl/ifc_fetch_fsm.sv
hdl/ifc_addr_sel.sv
hdl/ifc_req_pipe.sv
hdl/ifc_fb_credit.sv
hdl/ifc_mem_attr.sv
hdl/ifc_fetch_top.sv
test/ifc_clk_gen.sv
test/ifc_fetch_tb.sv
